// ==== ball_motion.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_motion (
	input  wire logic             CLOCK_50,
	input  wire logic             rst_n,
	input  wire game_pkg::phase_e phase,
	input  wire logic             frame_step,
	input  wire logic             new_round,
	input  wire logic             bounce_y,
	input  wire game_pkg::pos_t   paddle,
	output game_pkg::ball_t       ball,
	output logic                  lost
);

	game_pkg::coord_t nx;
	game_pkg::coord_t ny;
	logic n_right;
	logic n_down;
	logic on_paddle;

	assign lost = ball.pos.y >= game_pkg::SCREEN_H;

	// next position and direction after one step
	always_comb begin
		nx = ball.right ? ball.pos.x + 8'd1 : ball.pos.x - 8'd1;
		ny = ball.down ? ball.pos.y + 8'd1 : ball.pos.y - 8'd1;
		n_right = ball.right;
		n_down = ball.down;
		on_paddle = ball.down && (ny == game_pkg::PADDLE_Y - 8'd1 || ny == game_pkg::PADDLE_Y)
			&& nx >= paddle.x && nx <= paddle.x + game_pkg::PADDLE_LEN - 8'd1;
		if (on_paddle) begin
			n_down = 1'b0;
			if (!paddle.x[0])
				n_right = !n_right;  // even paddle x deflects
		end
		if (nx == 8'd0)
			n_right = 1'b1;  // walls win over deflection
		else if (nx >= game_pkg::BALL_X_MAX)
			n_right = 1'b0;
		if (ny == 8'd0)
			n_down = 1'b1;
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			ball <= '{pos: '{x: game_pkg::BALL_X0, y: game_pkg::BALL_Y0}, right: 1'b1, down: 1'b0};
		end else if (new_round || phase == game_pkg::LOST) begin
			ball <= '{pos: '{x: game_pkg::BALL_X0, y: game_pkg::BALL_Y0}, right: 1'b1, down: 1'b0};
		end else if (frame_step && phase == game_pkg::MOVE_BALL) begin
			ball <= '{pos: '{x: nx, y: ny}, right: n_right, down: n_down};
		end else if (bounce_y) begin
			ball.down <= !ball.down;  // brick hit
		end
	end

endmodule

`default_nettype wire

// ==== breakout_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module breakout_props (
	input wire logic              CLOCK_50,
	input wire logic              rst_n,
	input wire video_pkg::pixel_t pixel,
	input wire logic              paint_done,
	input wire video_pkg::seg_t   hex0,
	input wire video_pkg::seg_t   hex1,
	input wire video_pkg::seg_t   hex4,
	input wire video_pkg::seg_t   hex5,
	input wire video_pkg::seg_t   hex6,
	input wire video_pkg::seg_t   hex7
);

	localparam logic [6:0] DIGIT_0  = 7'b1000000;
	localparam logic [6:0] LETTER_H = 7'b0001001;
	localparam logic [6:0] LETTER_I = 7'b1001111;

	int fail_cnt = 0;  // read by the testbench
	logic first_done;  // first full screen clear finished
	int first_cnt;

	always @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			first_done <= 1'b0;
			first_cnt <= 0;
		end else if (!first_done) begin
			first_cnt <= first_cnt + int'(pixel.plot);
			if (paint_done)
				first_done <= 1'b1;
		end
	end

	a_reset: assert property (@(posedge CLOCK_50) !rst_n |-> !pixel.plot
		&& hex0 == DIGIT_0 && hex1 == DIGIT_0 && hex4 == DIGIT_0 && hex5 == DIGIT_0)
		else begin fail_cnt++; $error("outputs not idle or score not 00 in reset"); end

	a_label: assert property (@(posedge CLOCK_50) hex7 == LETTER_H && hex6 == LETTER_I)
		else begin fail_cnt++; $error("HI label missing on hex7/hex6"); end

	a_on_screen: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		pixel.plot |-> pixel.x < 8'd160 && pixel.y < 8'd120)
		else begin fail_cnt++; $error("pixel plotted off screen"); end

	a_first_black: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		pixel.plot && !first_done |-> pixel.colour == 3'b000)
		else begin fail_cnt++; $error("first clear is not black"); end

	a_first_size: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		paint_done && !first_done |-> first_cnt + 1 == 19200)
		else begin fail_cnt++; $error("first clear does not cover the screen"); end

endmodule

bind breakout_top breakout_props props_i (
	.CLOCK_50(CLOCK_50), .rst_n(rst_n), .pixel(pixel), .paint_done(paint_done),
	.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
);

`default_nettype wire

// ==== breakout_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module breakout_top #(
	parameter int FRAME_CYCLES = 833_333
) (
	input  wire logic            CLOCK_50,
	input  wire logic            rst_n,
	input  wire game_pkg::keys_t keys,
	output video_pkg::pixel_t    pixel,
	output video_pkg::seg_t      hex0,
	output video_pkg::seg_t      hex1,
	output video_pkg::seg_t      hex4,
	output video_pkg::seg_t      hex5,
	output video_pkg::seg_t      hex6,
	output video_pkg::seg_t      hex7
);

	game_pkg::phase_e phase;
	logic frame_step;
	logic new_round;
	logic paint_start;
	logic paint_done;
	game_pkg::pos_t rect_origin;
	game_pkg::coord_t rect_w;
	game_pkg::coord_t rect_h;
	video_pkg::colour_t rect_colour;
	game_pkg::pos_t paddle;
	game_pkg::ball_t ball;
	logic lost;
	logic bounce_y;
	logic [game_pkg::NUM_BRICKS-1:0] alive;
	video_pkg::score_t score;
	video_pkg::score_t hi_score;

	game_seq #(.FRAME_CYCLES(FRAME_CYCLES)) game_seq_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .keys(keys), .paint_done(paint_done),
		.alive(alive), .lost(lost), .paddle(paddle), .ball(ball),
		.phase(phase), .frame_step(frame_step), .new_round(new_round),
		.paint_start(paint_start), .rect_origin(rect_origin), .rect_w(rect_w),
		.rect_h(rect_h), .rect_colour(rect_colour)
	);

	rect_painter rect_painter_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .paint_start(paint_start),
		.rect_origin(rect_origin), .rect_w(rect_w), .rect_h(rect_h),
		.rect_colour(rect_colour), .pixel(pixel), .paint_done(paint_done)
	);

	paddle_motion paddle_motion_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .keys(keys), .phase(phase),
		.frame_step(frame_step), .new_round(new_round), .paddle(paddle)
	);

	ball_motion ball_motion_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .phase(phase), .frame_step(frame_step),
		.new_round(new_round), .bounce_y(bounce_y), .paddle(paddle),
		.ball(ball), .lost(lost)
	);

	brick_field brick_field_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .phase(phase), .frame_step(frame_step),
		.new_round(new_round), .keys(keys), .ball(ball), .alive(alive),
		.bounce_y(bounce_y), .score(score), .hi_score(hi_score)
	);

	score_display score_display_i (
		.score(score), .hi_score(hi_score), .hex0(hex0), .hex1(hex1),
		.hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

endmodule

`default_nettype wire

// ==== brick_field.sv ====
`timescale 1ns/100ps
`default_nettype none

module brick_field (
	input  wire logic                      CLOCK_50,
	input  wire logic                      rst_n,
	input  wire game_pkg::phase_e          phase,
	input  wire logic                      frame_step,
	input  wire logic                      new_round,
	input  wire game_pkg::keys_t           keys,
	input  wire game_pkg::ball_t           ball,
	output logic [game_pkg::NUM_BRICKS-1:0] alive,
	output logic                           bounce_y,
	output video_pkg::score_t              score,
	output video_pkg::score_t              hi_score
);

	logic [game_pkg::NUM_BRICKS-1:0] hit;
	video_pkg::score_t hit_cnt;
	logic restart;

	assign restart = (phase == game_pkg::LOST) && keys.restart;

	// ball against every live brick box
	always_comb begin
		hit_cnt = '0;
		for (int i = 0; i < game_pkg::NUM_BRICKS; i++) begin
			hit[i] = alive[i]
				&& ball.pos.x >= game_pkg::brick_x[i]
				&& ball.pos.x <= game_pkg::brick_x[i] + game_pkg::BRICK_W - 8'd1
				&& ball.pos.y >= game_pkg::brick_y[i]
				&& ball.pos.y <= game_pkg::brick_y[i] + game_pkg::BRICK_H - 8'd1;
			hit_cnt = hit_cnt + video_pkg::score_t'(hit[i]);
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			alive <= '1;
			bounce_y <= 1'b0;
			score <= '0;
			hi_score <= '0;
		end else begin
			bounce_y <= 1'b0;
			if (new_round || restart) begin
				alive <= '1;
			end else if (frame_step && phase == game_pkg::MOVE_PADDLE) begin
				alive <= alive & ~hit;
				score <= score + hit_cnt;  // one point per brick
				bounce_y <= |hit;
			end
			if (phase == game_pkg::LOST) begin
				if (score > hi_score)
					hi_score <= score;
				score <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== build.f ====
video_pkg.sv
game_pkg.sv
game_seq.sv
rect_painter.sv
paddle_motion.sv
ball_motion.sv
brick_field.sv
score_display.sv
breakout_top.sv
breakout_props.sv
tb_breakout.sv

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

	typedef logic [7:0] coord_t;

	localparam coord_t SCREEN_W   = 8'd160;
	localparam coord_t SCREEN_H   = 8'd120;
	localparam coord_t PADDLE_Y   = 8'd110;
	localparam coord_t PADDLE_LEN = 8'd16;
	localparam coord_t PADDLE_X0  = 8'd76;
	localparam coord_t BALL_X0    = 8'd80;
	localparam coord_t BALL_Y0    = 8'd108;
	localparam coord_t BALL_X_MAX = 8'd157;
	localparam coord_t BRICK_W    = 8'd8;
	localparam coord_t BRICK_H    = 8'd4;
	localparam int     NUM_BRICKS = 10;

	// three rows: red, cyan, blue
	localparam coord_t brick_x [NUM_BRICKS] = '{
		8'd34, 8'd46, 8'd58, 8'd88, 8'd100, 8'd112, 8'd124, 8'd34, 8'd46, 8'd58
	};
	localparam coord_t brick_y [NUM_BRICKS] = '{
		8'd30, 8'd30, 8'd30, 8'd38, 8'd38, 8'd38, 8'd38, 8'd45, 8'd45, 8'd45
	};
	localparam video_pkg::colour_t brick_colour [NUM_BRICKS] = '{
		3'b100, 3'b100, 3'b100, 3'b011, 3'b011, 3'b011, 3'b011, 3'b001, 3'b001, 3'b001
	};

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	typedef struct packed {
		pos_t pos;
		logic right;  // moving +x
		logic down;   // moving +y
	} ball_t;

	typedef struct packed {
		logic left;
		logic right;
		logic restart;
	} keys_t;

	typedef enum logic [3:0] {
		CLEAR,
		IDLE,
		DRAW_BRICKS,
		ERASE_PADDLE,
		MOVE_PADDLE,
		DRAW_PADDLE,
		ERASE_BALL,
		MOVE_BALL,
		DRAW_BALL,
		CHECK_WIN,
		LOST
	} phase_e;

endpackage

`default_nettype wire

// ==== game_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_seq #(
	parameter int FRAME_CYCLES = 833_333
) (
	input  wire logic                            CLOCK_50,
	input  wire logic                            rst_n,
	input  wire game_pkg::keys_t                 keys,
	input  wire logic                            paint_done,
	input  wire logic [game_pkg::NUM_BRICKS-1:0] alive,
	input  wire logic                            lost,
	input  wire game_pkg::pos_t                  paddle,
	input  wire game_pkg::ball_t                 ball,
	output game_pkg::phase_e                     phase,
	output logic                                 frame_step,
	output logic                                 new_round,
	output logic                                 paint_start,
	output game_pkg::pos_t                       rect_origin,
	output game_pkg::coord_t                     rect_w,
	output game_pkg::coord_t                     rect_h,
	output video_pkg::colour_t                   rect_colour
);

	logic [$clog2(FRAME_CYCLES)-1:0] div_cnt;
	logic tick;
	logic busy;  // painter is sweeping
	logic held;  // red screen finished
	logic [$clog2(game_pkg::NUM_BRICKS)-1:0] brick_idx;
	logic paint_phase;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (int'(div_cnt) == FRAME_CYCLES - 1) begin
			div_cnt <= '0;
			tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

	assign paint_phase = phase inside {game_pkg::CLEAR, game_pkg::DRAW_BRICKS,
		game_pkg::ERASE_PADDLE, game_pkg::DRAW_PADDLE, game_pkg::ERASE_BALL,
		game_pkg::DRAW_BALL, game_pkg::LOST};
	assign paint_start = paint_phase && !busy && !held;
	assign frame_step = (phase == game_pkg::MOVE_PADDLE) || (phase == game_pkg::MOVE_BALL);
	assign new_round = (phase == game_pkg::CHECK_WIN) && !lost && (alive == '0);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			phase <= game_pkg::CLEAR;
			busy <= 1'b0;
			held <= 1'b0;
			brick_idx <= '0;
		end else begin
			if (paint_start)
				busy <= 1'b1;
			else if (paint_done)
				busy <= 1'b0;
			case (phase)
				game_pkg::CLEAR: if (paint_done) phase <= game_pkg::IDLE;
				game_pkg::IDLE: if (tick) phase <= game_pkg::DRAW_BRICKS;  // late ticks are lost
				game_pkg::DRAW_BRICKS: begin
					if (paint_done) begin
						if (int'(brick_idx) == game_pkg::NUM_BRICKS - 1) begin
							brick_idx <= '0;
							phase <= game_pkg::ERASE_PADDLE;
						end else begin
							brick_idx <= brick_idx + 1'b1;
						end
					end
				end
				game_pkg::ERASE_PADDLE: if (paint_done) phase <= game_pkg::MOVE_PADDLE;
				game_pkg::MOVE_PADDLE: phase <= game_pkg::DRAW_PADDLE;
				game_pkg::DRAW_PADDLE: if (paint_done) phase <= game_pkg::ERASE_BALL;
				game_pkg::ERASE_BALL: if (paint_done) phase <= game_pkg::MOVE_BALL;
				game_pkg::MOVE_BALL: phase <= game_pkg::DRAW_BALL;
				game_pkg::DRAW_BALL: if (paint_done) phase <= game_pkg::CHECK_WIN;
				game_pkg::CHECK_WIN: begin
					if (lost)
						phase <= game_pkg::LOST;
					else if (alive == '0)
						phase <= game_pkg::CLEAR;  // won, fresh field
					else
						phase <= game_pkg::IDLE;
				end
				game_pkg::LOST: begin
					if (paint_done)
						held <= 1'b1;
					if (held && keys.restart) begin
						held <= 1'b0;
						phase <= game_pkg::CLEAR;
					end
				end
				default: phase <= game_pkg::CLEAR;
			endcase
		end
	end

	// rectangle for the current phase
	always_comb begin
		rect_origin = '0;
		rect_w = game_pkg::SCREEN_W;
		rect_h = game_pkg::SCREEN_H;
		rect_colour = video_pkg::BLACK;
		case (phase)
			game_pkg::LOST: rect_colour = video_pkg::RED;
			game_pkg::DRAW_BRICKS: begin
				rect_origin = '{x: game_pkg::brick_x[brick_idx], y: game_pkg::brick_y[brick_idx]};
				rect_w = game_pkg::BRICK_W;
				rect_h = game_pkg::BRICK_H;
				rect_colour = alive[brick_idx] ? game_pkg::brick_colour[brick_idx]
					: video_pkg::BLACK;
			end
			game_pkg::ERASE_PADDLE, game_pkg::DRAW_PADDLE: begin
				rect_origin = paddle;
				rect_w = game_pkg::PADDLE_LEN;
				rect_h = 8'd2;  // two rows thick
				if (phase == game_pkg::DRAW_PADDLE)
					rect_colour = video_pkg::WHITE;
			end
			game_pkg::ERASE_BALL, game_pkg::DRAW_BALL: begin
				rect_origin = ball.pos;
				rect_w = 8'd1;
				rect_h = 8'd1;
				if (phase == game_pkg::DRAW_BALL)
					rect_colour = video_pkg::WHITE;
			end
			default: rect_colour = video_pkg::BLACK;  // full screen clear
		endcase
	end

endmodule

`default_nettype wire

// ==== paddle_motion.sv ====
`timescale 1ns/100ps
`default_nettype none

module paddle_motion (
	input  wire logic             CLOCK_50,
	input  wire logic             rst_n,
	input  wire game_pkg::keys_t  keys,
	input  wire game_pkg::phase_e phase,
	input  wire logic             frame_step,
	input  wire logic             new_round,
	output game_pkg::pos_t        paddle
);

	game_pkg::coord_t px;
	logic restart;

	assign restart = (phase == game_pkg::LOST) && keys.restart;
	assign paddle = '{x: px, y: game_pkg::PADDLE_Y};  // row never changes

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			px <= game_pkg::PADDLE_X0;
		end else if (new_round || restart) begin
			px <= game_pkg::PADDLE_X0;
		end else if (frame_step && phase == game_pkg::MOVE_PADDLE) begin
			if (keys.right && px < game_pkg::SCREEN_W - game_pkg::PADDLE_LEN)
				px <= px + 8'd1;
			else if (keys.left && px > 8'd0)
				px <= px - 8'd1;
		end
	end

endmodule

`default_nettype wire

// ==== rect_painter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rect_painter (
	input  wire logic               CLOCK_50,
	input  wire logic               rst_n,
	input  wire logic               paint_start,
	input  wire game_pkg::pos_t     rect_origin,
	input  wire game_pkg::coord_t   rect_w,
	input  wire game_pkg::coord_t   rect_h,
	input  wire video_pkg::colour_t rect_colour,
	output video_pkg::pixel_t       pixel,
	output logic                    paint_done
);

	logic active;
	game_pkg::pos_t org;
	game_pkg::coord_t w;
	game_pkg::coord_t h;
	video_pkg::colour_t colour;
	game_pkg::coord_t col;
	game_pkg::coord_t row;
	logic [8:0] px;  // one spare bit to catch wrap
	logic [8:0] py;
	logic on_screen;

	assign px = {1'b0, org.x} + {1'b0, col};
	assign py = {1'b0, org.y} + {1'b0, row};
	assign on_screen = (px < {1'b0, game_pkg::SCREEN_W}) && (py < {1'b0, game_pkg::SCREEN_H});
	assign paint_done = active && (col == w - 8'd1) && (row == h - 8'd1);
	assign pixel = '{plot: active && on_screen, x: px[7:0], y: py[7:0], colour: colour};

	always_ff @(posedge CLOCK_50) begin
		if (paint_start) begin
			org <= rect_origin;
			w <= rect_w;
			h <= rect_h;
			colour <= rect_colour;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (paint_start) begin
			active <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (active) begin
			if (paint_done)
				active <= 1'b0;
			if (col == w - 8'd1) begin  // row major sweep
				col <= '0;
				row <= row + 8'd1;
			end else begin
				col <= col + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the breakout testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module tb_breakout -o tb_breakout; then
	echo "verilator compile failed"
	exit 1
fi

# keep running after an assertion error so the testbench reports it
./obj_dir/tb_breakout +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== score_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module score_display (
	input  wire video_pkg::score_t score,
	input  wire video_pkg::score_t hi_score,
	output video_pkg::seg_t        hex0,
	output video_pkg::seg_t        hex1,
	output video_pkg::seg_t        hex4,
	output video_pkg::seg_t        hex5,
	output video_pkg::seg_t        hex6,
	output video_pkg::seg_t        hex7
);

	// current score on the right pair
	assign hex0 = video_pkg::SEG_HEX[score[3:0]];
	assign hex1 = video_pkg::SEG_HEX[score[7:4]];

	// best score next to the label
	assign hex4 = video_pkg::SEG_HEX[hi_score[3:0]];
	assign hex5 = video_pkg::SEG_HEX[hi_score[7:4]];

	assign hex6 = video_pkg::SEG_I;
	assign hex7 = video_pkg::SEG_H;  // "HI" label, fixed

endmodule

`default_nettype wire

// ==== tb_breakout.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_breakout;

	localparam int FRAME_CYCLES = 400;
	localparam int SCREEN_PIXELS = 160 * 120;
	localparam int PADDLE_START = 76;
	localparam int PADDLE_MAX = 144;  // 160 minus paddle length
	localparam int RANDOM_FRAMES = 20;
	localparam int LEFT_FRAMES = 100;  // long enough to rest on the left wall
	localparam int RIGHT_FRAMES = 150;  // crosses over and rests on the right wall
	localparam int LOSS_FRAMES = 400;  // ball falls after about 310 frames
	// a frame takes two ticks, plus four full screen paints, doubled
	localparam int TIMEOUT_CYCLES = (2 * LOSS_FRAMES * FRAME_CYCLES + 4 * SCREEN_PIXELS) * 2;

	localparam logic [6:0] SEG_TABLE [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	logic CLOCK_50;
	logic rst_n;
	game_pkg::keys_t keys;
	game_pkg::keys_t next_keys;  // applied after the next edge
	video_pkg::pixel_t pixel;
	video_pkg::seg_t hex0;
	video_pkg::seg_t hex1;
	video_pkg::seg_t hex4;
	video_pkg::seg_t hex5;
	video_pkg::seg_t hex6;
	video_pkg::seg_t hex7;

	logic [31:0] rng;
	int fs_cnt;
	video_pkg::colour_t fs_colour;
	int run_len;
	int run_left;
	int run_last;
	int run_row;
	int paddle_left;
	int paddle_runs;
	logic prev_plot;
	int cand_brick;
	video_pkg::colour_t cand_colour;
	logic [9:0] dead;
	logic [9:0] colour_seen;
	int destroyed;
	int hi_model;
	int stage;  // 0 playing, 1 red screen seen, 2 restarted

	breakout_top #(.FRAME_CYCLES(FRAME_CYCLES)) breakout_top_i (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n), .keys(keys), .pixel(pixel),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int seg_digit(input video_pkg::seg_t s);
		for (int d = 0; d < 16; d++)
			if (s == SEG_TABLE[d])
				return d;
		return -1;
	endfunction

	// two digit hex readout, -1 if a digit is garbage
	function automatic int read_pair(input video_pkg::seg_t hi, input video_pkg::seg_t lo);
		int h;
		int l;
		h = seg_digit(hi);
		l = seg_digit(lo);
		if (h < 0 || l < 0)
			return -1;
		return h * 16 + l;
	endfunction

	task automatic report_failure(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic finish_run();
		if (breakout_top_i.props_i.fail_cnt == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic screen_done(input video_pkg::colour_t colour);
		int sc;
		int hs;
		sc = read_pair(hex1, hex0);
		hs = read_pair(hex5, hex4);
		dead = '0;
		if (colour == video_pkg::RED) begin
			hi_model = (destroyed > hi_model) ? destroyed : hi_model;
			assert (sc == 0 && hs == hi_model) else report_failure($sformatf(
				"after loss score %0d hi %0d, expected 0 and %0d", sc, hs, hi_model));
			destroyed = 0;
			stage = 1;
			next_keys = '0;
			next_keys.restart = 1'b1;  // held until the black clear
		end else begin
			paddle_left = PADDLE_START;  // paddle is back home after any clear
			if (stage == 1) begin
				stage = 2;
				colour_seen = '0;
				next_keys = '0;
			end
		end
	endtask

	// full screen paint shows up as 19200 plots in raster order
	task automatic track_screen();
		if (!pixel.plot) begin
			fs_cnt = 0;
		end else if (pixel.x == 8'd0 && pixel.y == 8'd0) begin
			fs_cnt = 1;
			fs_colour = pixel.colour;
		end else if (fs_cnt > 0 && int'(pixel.x) == fs_cnt % 160
				&& int'(pixel.y) == fs_cnt / 160 && pixel.colour == fs_colour) begin
			fs_cnt++;
		end else begin
			fs_cnt = 0;
		end
		if (fs_cnt == SCREEN_PIXELS) begin
			fs_cnt = 0;
			screen_done(fs_colour);
		end
	endtask

	task automatic paddle_run_done();
		int expect_left;
		expect_left = paddle_left;
		if (run_row == 110) begin
			if (keys.right && paddle_left < PADDLE_MAX)
				expect_left = paddle_left + 1;
			else if (keys.left && paddle_left > 0)
				expect_left = paddle_left - 1;
		end
		assert (run_len == 16) else report_failure($sformatf(
			"paddle run at x %0d is %0d pixels wide", run_left, run_len));
		assert (run_left == expect_left) else report_failure($sformatf(
			"paddle at x %0d, expected %0d", run_left, expect_left));
		paddle_left = run_left;
		if (run_row == 110) begin
			paddle_runs++;
			next_keys = '0;
			if (stage == 0 && paddle_runs < RANDOM_FRAMES) begin
				rng = xorshift(rng);
				next_keys.left = (rng[1:0] == 2'd1);
				next_keys.right = (rng[1:0] == 2'd2);
			end else if (stage == 0 && paddle_runs < RANDOM_FRAMES + LEFT_FRAMES) begin
				next_keys.left = 1'b1;
			end else if (stage == 0
					&& paddle_runs < RANDOM_FRAMES + LEFT_FRAMES + RIGHT_FRAMES) begin
				next_keys.right = 1'b1;  // then idle until the ball falls
			end
		end
	endtask

	// white runs in rows 110 and 111, single dots are the ball
	task automatic track_paddle();
		logic in_row;
		in_row = pixel.plot && pixel.colour == video_pkg::WHITE
			&& (pixel.y == 8'd110 || pixel.y == 8'd111);
		if (in_row && run_len > 0 && int'(pixel.y) == run_row
				&& int'(pixel.x) == run_last + 1) begin
			run_len++;
			run_last = int'(pixel.x);
		end else begin
			if (run_len > 1)
				paddle_run_done();
			run_len = in_row ? 1 : 0;
			run_left = int'(pixel.x);
			run_last = int'(pixel.x);
			run_row = int'(pixel.y);
		end
	endtask

	task automatic brick_painted(input int i, input video_pkg::colour_t c);
		int sc;
		if (c == game_pkg::brick_colour[i]) begin
			assert (!dead[i]) else report_failure($sformatf(
				"brick %0d painted in colour after it was cleared", i));
			if (stage == 2)
				colour_seen[i] = 1'b1;
		end else if (c == video_pkg::BLACK && !dead[i]) begin
			dead[i] = 1'b1;
			destroyed++;
		end
		if (i == game_pkg::NUM_BRICKS - 1) begin
			sc = read_pair(hex1, hex0);
			assert (sc == destroyed) else report_failure($sformatf(
				"score %0d, expected %0d", sc, destroyed));
		end
	endtask

	// a brick paint starts after an idle cycle and runs on along its row
	task automatic track_bricks();
		int i;
		if (cand_brick >= 0) begin
			if (pixel.plot && pixel.colour == cand_colour
					&& pixel.x == game_pkg::brick_x[cand_brick] + 8'd1
					&& pixel.y == game_pkg::brick_y[cand_brick])
				brick_painted(cand_brick, cand_colour);
			cand_brick = -1;
		end
		if (pixel.plot && !prev_plot) begin
			for (i = 0; i < game_pkg::NUM_BRICKS; i++) begin
				if (pixel.x == game_pkg::brick_x[i] && pixel.y == game_pkg::brick_y[i]) begin
					cand_brick = i;
					cand_colour = pixel.colour;
				end
			end
		end
		prev_plot = pixel.plot;
	endtask

	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		rst_n = 1'b1;
		keys = '0;
		next_keys = '0;
		rng = 32'd44892;
		fs_cnt = 0;
		fs_colour = '0;
		run_len = 0;
		run_left = 0;
		run_last = 0;
		run_row = 0;
		paddle_left = PADDLE_START;
		paddle_runs = 0;
		prev_plot = 1'b0;
		cand_brick = -1;
		cand_colour = '0;
		dead = '0;
		colour_seen = '0;
		destroyed = 0;
		hi_model = 0;
		stage = 0;
		#1 rst_n = 1'b0;
		repeat (3) @(posedge CLOCK_50);
		#1 rst_n = 1'b1;
	end

	always @(posedge CLOCK_50) begin
		#1;
		keys = next_keys;
	end

	// outputs are settled mid cycle
	always @(negedge CLOCK_50) begin
		if (rst_n) begin
			assert (breakout_top_i.props_i.fail_cnt == 0)
				else report_failure("a property in breakout_props failed");
			track_screen();
			track_paddle();
			track_bricks();
			if (stage == 2 && colour_seen == '1)
				finish_run();
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 4);
		$display("watchdog expired before the loss and restart were seen");
		$display("Regression failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

	typedef logic [2:0] colour_t;  // r g b, one bit each

	localparam colour_t BLACK = 3'b000;
	localparam colour_t WHITE = 3'b111;
	localparam colour_t RED   = 3'b100;

	// one entry of the pixel write stream
	typedef struct packed {
		logic       plot;
		logic [7:0] x;
		logic [7:0] y;
		colour_t    colour;
	} pixel_t;

	typedef logic [6:0] seg_t;  // active low, segment g is the msb
	typedef logic [7:0] score_t;

	localparam seg_t SEG_H = 7'b0001001;
	localparam seg_t SEG_I = 7'b1001111;

	// hex digit to segments
	localparam seg_t SEG_HEX [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

endpackage

`default_nettype wire
